//--- dv/isaModel.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module isaModel
    import cpuIsaPkg::*;
();

    localparam int DmemIdxW = $clog2(`SOC_DMEM_WORDS);
    localparam int MaxSteps = 1000;

    // the data RAM is not cleared by reset, so it lives outside the task
    logic [31:0] dmem [`SOC_DMEM_WORDS];

    // runs a program from pc 0 and lists the stores that change the LED value
    task automatic runProgram(
        input  logic [31:0] words [$],
        output logic [7:0]  ledChanges [$],
        output logic [7:0]  finalLed
    );
        logic [31:0] regs [`SOC_NUM_REGS];
        logic [31:0] instr;
        logic [31:0] raVal;
        logic [31:0] rbVal;
        logic [31:0] rdVal;
        logic [31:0] immExt;
        logic [31:0] addr;
        logic [31:0] result;
        logic [31:0] pc;
        logic [7:0]  ledReg;
        logic        writeRd;
        logic        running;
        opcodeT      op;
        int          steps;
        pc = '0;
        ledReg = '0;
        running = 1'b1;
        steps = 0;
        ledChanges.delete();
        for (int i = 0; i < `SOC_NUM_REGS; i++) begin
            regs[i] = '0;
        end
        while (running) begin
            instr = (pc < words.size()) ? words[pc] : {HALT, 28'd0};
            op = opcodeT'(instr[31:28]);
            raVal = regs[instr[24:22]];
            rbVal = regs[instr[21:19]];
            rdVal = regs[instr[27:25]];
            immExt = {{16{instr[15]}}, instr[15:0]};
            addr = raVal + immExt;
            result = '0;
            writeRd = 1'b1;
            pc = pc + 1;
            steps++;
            case (op)
                ADDI: result = raVal + immExt;
                ADD: result = raVal + rbVal;
                SUB: result = raVal - rbVal;
                AND: result = raVal & rbVal;
                // bit 31 selects the LED register, read back with zeros above it
                LOAD: result = addr[31] ? {24'd0, ledReg} : dmem[addr[DmemIdxW-1:0]];
                STORE: begin
                    writeRd = 1'b0;
                    if (!addr[31]) begin
                        dmem[addr[DmemIdxW-1:0]] = rdVal;
                    end else if (rdVal[7:0] != ledReg) begin
                        ledChanges.push_back(rdVal[7:0]);
                        ledReg = rdVal[7:0];
                    end
                end
                BEQZ: begin
                    writeRd = 1'b0;
                    if (rdVal == '0) begin
                        pc = {16'd0, instr[15:0]};
                    end
                end
                JMP: begin
                    writeRd = 1'b0;
                    pc = {16'd0, instr[15:0]};
                end
                default: begin
                    writeRd = 1'b0;
                    running = 1'b0;
                end
            endcase
            if (writeRd && instr[27:25] != 3'd0) begin
                regs[instr[27:25]] = result;
            end
            if (steps >= MaxSteps) begin
                running = 1'b0;
            end
        end
        finalLed = ledReg;
    endtask

endmodule

`default_nettype wire

//--- dv/tbSoc.sv
`timescale 1ns/1ps
`default_nettype none

module tbSoc
    import cpuIsaPkg::*, socBusPkg::*;
();

    localparam int NumRandom = 40;
    localparam int MaxInstrs = 64;
    // execution at 6 cycles per instruction, plus boot and reset, for every program
    localparam int WatchdogCycles = (NumRandom + 4) * (MaxInstrs * 6 + MaxInstrs + 10);
    localparam int LedAddr = 'h8000;

    logic       Clock;
    logic       rstN;
    logic       bootValid;
    wordT       bootWord;
    logic       bootLast;
    logic [7:0] led;
    logic       halted;

    wordT       progWords [$];
    logic [7:0] expectedLeds [$];
    logic [7:0] lastLed;
    string      currentTest;
    int         errorCount;

    socTop uut (
        .Clock     (Clock),
        .rstN      (rstN),
        .bootValid (bootValid),
        .bootWord  (bootWord),
        .bootLast  (bootLast),
        .led       (led),
        .halted    (halted)
    );

    isaModel model ();

    always #5 Clock = ~Clock;

    initial begin
        #(WatchdogCycles * 10);
        $display("timeout: the run did not finish within %0d cycles", WatchdogCycles);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    function automatic wordT encode(opcodeT op, int rd, int ra, int rb, int imm);
        return {op, 3'(rd), 3'(ra), 3'(rb), 3'b000, 16'(imm)};
    endfunction

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: expected 0x%08h, actual 0x%08h", testName, expected, actual);
            $display("TB FAILED");
            $fatal(1, "value mismatch in %s", testName);
        end
    endtask

    task automatic failRun(input string reason);
        errorCount++;
        $display("%s: %s", currentTest, reason);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    // led is sampled at the rising edge, before the DUT updates it
    always @(posedge Clock) begin
        if (!rstN) begin
            lastLed = '0;
        end else if (led !== lastLed) begin
            if (expectedLeds.size() == 0) begin
                failRun("led changed although the model expects no further write");
            end else begin
                checkValue({currentTest, " led write"}, 32'(expectedLeds.pop_front()), 32'(led));
            end
            lastLed = led;
        end
    end

    task automatic resetDut();
        @(negedge Clock);
        rstN = 1'b0;
        repeat (8) @(negedge Clock);
        checkValue({currentTest, " led in reset"}, 0, 32'(led));
        checkValue({currentTest, " halted in reset"}, 0, 32'(halted));
        rstN = 1'b1;
    endtask

    // led and halted must stay low for the whole boot stream
    task automatic bootProgram();
        for (int i = 0; i < progWords.size(); i++) begin
            @(negedge Clock);
            checkValue({currentTest, " led before run"}, 0, 32'(led));
            checkValue({currentTest, " halted before run"}, 0, 32'(halted));
            bootValid = 1'b1;
            bootWord = progWords[i];
            bootLast = (i == progWords.size() - 1);
        end
        @(negedge Clock);
        bootValid = 1'b0;
        bootLast = 1'b0;
        bootWord = '0;
    endtask

    task automatic runTest(input string name);
        logic [7:0] modelChanges [$];
        logic [7:0] modelFinal;
        currentTest = name;
        model.runProgram(progWords, modelChanges, modelFinal);
        expectedLeds = modelChanges;
        resetDut();
        bootProgram();
        while (!halted) begin
            @(negedge Clock);
        end
        @(posedge Clock);
        @(negedge Clock);
        if (expectedLeds.size() != 0) begin
            failRun("halted before every expected led write was seen");
        end
        checkValue({name, " final led"}, 32'(modelFinal), 32'(led));
    endtask

    task automatic buildRandomProgram();
        int total;
        int rd;
        int target;
        progWords.delete();
        total = 16 + $urandom_range(40, 20) + 1;
        for (int a = 0; a < 8; a++) begin
            rd = $urandom_range(7, 1);
            progWords.push_back(encode(ADDI, rd, 0, 0, $urandom));
            progWords.push_back(encode(STORE, rd, 0, 0, a));
        end
        for (int i = 16; i < total - 1; i++) begin
            rd = $urandom_range(7, 0);
            target = $urandom_range(total - 1, i + 1);
            case ($urandom_range(9, 0))
                0: progWords.push_back(encode(ADDI, rd, $urandom, 0, $urandom));
                1: progWords.push_back(encode(ADD, rd, $urandom, $urandom, 0));
                2: progWords.push_back(encode(SUB, rd, $urandom, $urandom, 0));
                3: progWords.push_back(encode(AND, rd, $urandom, $urandom, 0));
                4: progWords.push_back(encode(LOAD, rd, 0, 0, $urandom_range(7, 0)));
                5: progWords.push_back(encode(STORE, rd, 0, 0, $urandom_range(7, 0)));
                6, 7: progWords.push_back(encode(STORE, rd, 0, 0, LedAddr));
                8: progWords.push_back(encode(BEQZ, rd, 0, 0, target));
                default: progWords.push_back(encode(JMP, 0, 0, 0, target));
            endcase
        end
        progWords.push_back(encode(HALT, 0, 0, 0, 0));
    endtask

    initial begin
        Clock = 1'b0;
        rstN = 1'b0;
        bootValid = 1'b0;
        bootWord = '0;
        bootLast = 1'b0;
        lastLed = '0;
        errorCount = 0;
        currentTest = "startup";
        void'($urandom(52));

        progWords = '{encode(ADDI, 1, 0, 0, 'h1A5), encode(STORE, 1, 0, 0, LedAddr),
                      encode(HALT, 0, 0, 0, 0)};
        runTest("ledWrite");
        checkValue("ledWrite led", 'hA5, 32'(led));

        progWords = '{encode(ADDI, 1, 0, 0, 'h33), encode(STORE, 1, 0, 0, 5),
                      encode(LOAD, 2, 0, 0, 5), encode(ADD, 3, 2, 1, 0),
                      encode(STORE, 3, 0, 0, LedAddr), encode(HALT, 0, 0, 0, 0)};
        runTest("ramLoad");
        checkValue("ramLoad led", 'h66, 32'(led));

        // the low nibble comes from the path taken, 0xEE or 0x40 marks a wrong one
        progWords = '{encode(ADDI, 1, 0, 0, 1), encode(BEQZ, 1, 0, 0, 4),
                      encode(ADDI, 2, 0, 0, 'h10), encode(BEQZ, 0, 0, 0, 5),
                      encode(ADDI, 2, 0, 0, 'hEE), encode(JMP, 0, 0, 0, 7),
                      encode(ADDI, 2, 2, 0, 'h40), encode(ADDI, 2, 2, 0, 1),
                      encode(STORE, 2, 0, 0, LedAddr), encode(HALT, 0, 0, 0, 0)};
        runTest("branches");
        checkValue("branches led", 'h11, 32'(led));

        // a nonzero upper half in the readback leaves 0x0E on the LEDs
        progWords = '{encode(ADDI, 1, 0, 0, 'h1FE), encode(STORE, 1, 0, 0, LedAddr),
                      encode(LOAD, 2, 0, 0, LedAddr), encode(ADDI, 3, 2, 0, 1),
                      encode(ADDI, 5, 0, 0, 'hFF00), encode(AND, 4, 2, 5, 0),
                      encode(BEQZ, 4, 0, 0, 8), encode(ADDI, 3, 0, 0, 'h0E),
                      encode(STORE, 3, 0, 0, LedAddr), encode(HALT, 0, 0, 0, 0)};
        runTest("ledReadback");
        checkValue("ledReadback led", 'hFF, 32'(led));

        for (int n = 0; n < NumRandom; n++) begin
            buildRandomProgram();
            runTest($sformatf("random%0d", n));
        end

        if (errorCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- include/soc_params.svh
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// memory depths in 32-bit words
`define SOC_IMEM_WORDS 256
`define SOC_DMEM_WORDS 256

// register 0 is hardwired to zero
`define SOC_NUM_REGS 8

`define SOC_LED_WIDTH 8

`endif

//--- runSim.sh
#!/bin/sh
# build with Verilator, run, and scan the output for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tbSoc -f vlog.f -o simSoc &&
./obj_dir/simSoc | awk '{ print } /^TB PASSED$/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- source/bootLoader.sv
`timescale 1ns/1ps
`default_nettype none

module bootLoader
    import cpuIsaPkg::*, socBusPkg::*;
(
    input wire          Clock,
    input wire          rstN,
    input wire          bootValid,
    input wire wordT    bootWord,
    input wire          bootLast,
    output logic        fillWrite,
    output addrT        fillAddr,
    output instrT       fillData,
    output logic        run
);

    // words are only taken while the processor is still held
    assign fillWrite = bootValid && !run;
    assign fillData  = instrT'(bootWord);

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            fillAddr <= '0;
            run      <= 1'b0;
        end else if (fillWrite) begin
            fillAddr <= fillAddr + 32'd1;
            if (bootLast) begin
                run <= 1'b1;
            end
        end
    end

    noBootAfterRun: assert property (@(posedge Clock) disable iff (!rstN)
        run |-> !bootValid);

endmodule

`default_nettype wire

//--- source/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module cpuCore
    import cpuIsaPkg::*, socBusPkg::*;
(
    input wire         Clock,
    input wire         rstN,
    input wire         run,
    memBus.requester   instBus,
    memBus.requester   dataBus,
    output logic       halted
);

    typedef enum logic [2:0] {
        idle,
        fetch,
        waitFetch,
        execute,
        memory,
        waitMemory,
        stopped
    } stateT;

    stateT  state;
    addrT   pc;
    instrT  instr;
    wordT   regFile [`SOC_NUM_REGS];

    wordT   raVal;
    wordT   rbVal;
    wordT   rdVal;
    wordT   immExt;
    wordT   aluResult;
    addrT   effAddr;
    addrT   branchTarget;
    logic   writesRd;

    assign raVal        = regFile[instr.ra];
    assign rbVal        = regFile[instr.rb];
    assign rdVal        = regFile[instr.rd];
    assign immExt       = {{16{instr.imm[15]}}, instr.imm};
    assign effAddr      = raVal + immExt;
    assign branchTarget = {16'h0000, instr.imm};

    assign halted = (state == stopped);

    always_comb begin
        writesRd  = 1'b1;
        aluResult = '0;
        case (instr.opcode)
            ADDI: aluResult = raVal + immExt;
            ADD:  aluResult = raVal + rbVal;
            SUB:  aluResult = raVal - rbVal;
            AND:  aluResult = raVal & rbVal;
            default: writesRd = 1'b0;
        endcase
    end

    // the instruction register only loads on the fetch handshake
    always_ff @(posedge Clock) begin
        if (state == waitFetch && instBus.ready) begin
            instr <= instBus.rdata;
        end
    end

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            state         <= idle;
            pc            <= '0;
            instBus.read  <= 1'b0;
            instBus.write <= 1'b0;
            instBus.addr  <= '0;
            instBus.wdata <= '0;
            dataBus.read  <= 1'b0;
            dataBus.write <= 1'b0;
            dataBus.addr  <= '0;
            dataBus.wdata <= '0;
            for (int i = 0; i < `SOC_NUM_REGS; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            case (state)
                idle: begin
                    if (run) begin
                        state <= fetch;
                    end
                end
                fetch: begin
                    instBus.read <= 1'b1;
                    instBus.addr <= pc;
                    state        <= waitFetch;
                end
                waitFetch: begin
                    if (instBus.ready) begin
                        instBus.read <= 1'b0;
                        state        <= execute;
                    end
                end
                execute: begin
                    pc    <= pc + 32'd1;
                    state <= fetch;
                    if (writesRd && instr.rd != 3'd0) begin
                        regFile[instr.rd] <= aluResult;
                    end
                    case (instr.opcode)
                        ADDI, ADD, SUB, AND: ;
                        LOAD: begin
                            dataBus.read <= 1'b1;
                            dataBus.addr <= effAddr;
                            state        <= memory;
                        end
                        STORE: begin
                            dataBus.write <= 1'b1;
                            dataBus.addr  <= effAddr;
                            dataBus.wdata <= rdVal;
                            state         <= memory;
                        end
                        BEQZ: begin
                            if (rdVal == '0) begin
                                pc <= branchTarget;
                            end
                        end
                        JMP: pc <= branchTarget;
                        // HALT and every undefined opcode end the program here
                        default: begin
                            pc    <= pc;
                            state <= stopped;
                        end
                    endcase
                end
                // the responder sees the request in this cycle, ready cannot come yet
                memory: state <= waitMemory;
                waitMemory: begin
                    if (dataBus.ready) begin
                        dataBus.read  <= 1'b0;
                        dataBus.write <= 1'b0;
                        state         <= fetch;
                        if (instr.opcode == LOAD && instr.rd != 3'd0) begin
                            regFile[instr.rd] <= dataBus.rdata;
                        end
                    end
                end
                default: state <= stopped;
            endcase
        end
    end

    pcInRange: assert property (@(posedge Clock) disable iff (!rstN)
        pc < `SOC_IMEM_WORDS);

    instRequestHeld: assert property (@(posedge Clock) disable iff (!rstN)
        (instBus.read && !instBus.ready) |=> (instBus.read && $stable(instBus.addr)));

    dataRequestHeld: assert property (@(posedge Clock) disable iff (!rstN)
        ((dataBus.read || dataBus.write) && !dataBus.ready)
        |=> ($stable(dataBus.read) && $stable(dataBus.write) && $stable(dataBus.addr)));

endmodule

`default_nettype wire

//--- source/cpuIsaPkg.sv
`default_nettype none

package cpuIsaPkg;

    // every code not listed here executes as HALT
    typedef enum logic [3:0] {
        ADDI  = 4'h0,
        ADD   = 4'h1,
        SUB   = 4'h2,
        AND   = 4'h3,
        LOAD  = 4'h4,
        STORE = 4'h5,
        BEQZ  = 4'h6,
        JMP   = 4'h7,
        HALT  = 4'h8
    } opcodeT;

    // one instruction word, opcode in the top nibble
    typedef struct packed {
        opcodeT      opcode;
        logic [2:0]  rd;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [2:0]  unused;
        logic [15:0] imm;
    } instrT;

endpackage

`default_nettype wire

//--- source/memBus.sv
`timescale 1ns/1ps
`default_nettype none

interface memBus
    import socBusPkg::*;
#(
    parameter type payloadT = wordT
) ();

    logic    read;
    logic    write;
    addrT    addr;
    payloadT wdata;
    payloadT rdata;
    // one-cycle pulse, rdata is valid in the same cycle
    logic    ready;

    modport requester (output read, write, addr, wdata, input rdata, ready);

    modport responder (input read, write, addr, wdata, output rdata, ready);

endinterface

`default_nettype wire

//--- source/peripheralDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module peripheralDecoder
    import socBusPkg::*;
(
    input wire                          Clock,
    input wire                          rstN,
    memBus.responder                    cpu,
    memBus.requester                    ram,
    output logic [`SOC_LED_WIDTH-1:0]   led
);

    regionT                     region;
    logic                       ledSel;
    logic                       ledReady;
    logic [`SOC_LED_WIDTH-1:0]  ledReg;

    assign region = regionT'(cpu.addr[RegionBit]);
    assign ledSel = (cpu.read || cpu.write) && region == REGION_LED;

    // RAM accesses pass through untouched apart from the region bit
    assign ram.read  = cpu.read && region == REGION_RAM;
    assign ram.write = cpu.write && region == REGION_RAM;
    assign ram.addr  = {1'b0, cpu.addr[RegionBit-1:0]};
    assign ram.wdata = cpu.wdata;

    assign cpu.ready = (region == REGION_LED) ? ledReady : ram.ready;
    assign cpu.rdata = (region == REGION_LED)
                     ? {{($bits(wordT) - `SOC_LED_WIDTH){1'b0}}, ledReg}
                     : ram.rdata;

    assign led = ledReg;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            ledReady <= 1'b0;
            ledReg   <= '0;
        end else begin
            ledReady <= ledSel && !ledReady;
            if (ledSel && cpu.write && !ledReady) begin
                ledReg <= cpu.wdata[`SOC_LED_WIDTH-1:0];
            end
        end
    end

endmodule

`default_nettype wire

//--- source/socBusPkg.sv
`default_nettype none

package socBusPkg;

    typedef logic [31:0] wordT;

    // addresses count words, not bytes
    typedef logic [31:0] addrT;

    // the top address bit picks the region
    localparam int RegionBit = 31;

    typedef enum logic {
        REGION_RAM = 1'b0,
        REGION_LED = 1'b1
    } regionT;

endpackage

`default_nettype wire

//--- source/socTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module socTop
    import cpuIsaPkg::*, socBusPkg::*;
(
    input wire                          Clock,
    input wire                          rstN,
    input wire                          bootValid,
    input wire wordT                    bootWord,
    input wire                          bootLast,
    output logic [`SOC_LED_WIDTH-1:0]   led,
    output logic                        halted
);

    memBus #(.payloadT(instrT)) instBus ();
    memBus #(.payloadT(wordT))  dataBus ();
    memBus #(.payloadT(wordT))  ramBus ();

    logic   run;
    logic   fillWrite;
    addrT   fillAddr;
    instrT  fillData;

    bootLoader boot (
        .Clock     (Clock),
        .rstN      (rstN),
        .bootValid (bootValid),
        .bootWord  (bootWord),
        .bootLast  (bootLast),
        .fillWrite (fillWrite),
        .fillAddr  (fillAddr),
        .fillData  (fillData),
        .run       (run)
    );

    cpuCore cpu (
        .Clock   (Clock),
        .rstN    (rstN),
        .run     (run),
        .instBus (instBus.requester),
        .dataBus (dataBus.requester),
        .halted  (halted)
    );

    wordMemory #(.payloadT(instrT), .Depth(`SOC_IMEM_WORDS)) instMem (
        .Clock     (Clock),
        .rstN      (rstN),
        .bus       (instBus.responder),
        .fillWrite (fillWrite),
        .fillAddr  (fillAddr),
        .fillData  (fillData)
    );

    // the data RAM is only written by the processor
    wordMemory #(.payloadT(wordT), .Depth(`SOC_DMEM_WORDS)) dataMem (
        .Clock     (Clock),
        .rstN      (rstN),
        .bus       (ramBus.responder),
        .fillWrite (1'b0),
        .fillAddr  ('0),
        .fillData  ('0)
    );

    peripheralDecoder decoder (
        .Clock (Clock),
        .rstN  (rstN),
        .cpu   (dataBus.responder),
        .ram   (ramBus.requester),
        .led   (led)
    );

endmodule

`default_nettype wire

//--- source/wordMemory.sv
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module wordMemory
    import socBusPkg::*;
#(
    parameter type payloadT = wordT,
    parameter int  Depth    = `SOC_DMEM_WORDS
) (
    input wire           Clock,
    input wire           rstN,
    memBus.responder     bus,
    input wire           fillWrite,
    input wire addrT     fillAddr,
    input wire payloadT  fillData
);

    localparam int IdxW = $clog2(Depth);

    payloadT          mem [Depth];
    logic [IdxW-1:0]  busIdx;
    logic [IdxW-1:0]  fillIdx;
    logic             accept;

    assign busIdx  = bus.addr[IdxW-1:0];
    assign fillIdx = fillAddr[IdxW-1:0];

    // a request still held in its ready cycle is not taken a second time
    assign accept = (bus.read || bus.write) && !bus.ready;

    always_ff @(posedge Clock or negedge rstN) begin
        if (!rstN) begin
            bus.ready <= 1'b0;
        end else begin
            bus.ready <= accept;
        end
    end

    always_ff @(posedge Clock) begin
        if (fillWrite) begin
            mem[fillIdx] <= fillData;
        end else if (accept && bus.write) begin
            mem[busIdx] <= bus.wdata;
        end
        bus.rdata <= mem[busIdx];
    end

    readWriteExclusive: assert property (@(posedge Clock) disable iff (!rstN)
        !(bus.read && bus.write));

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
source/cpuIsaPkg.sv
source/socBusPkg.sv
source/memBus.sv
source/wordMemory.sv
source/cpuCore.sv
source/peripheralDecoder.sv
source/bootLoader.sv
source/socTop.sv
dv/isaModel.sv
dv/tbSoc.sv
